// ==== flist.f ====
rtl/cart_pkg.sv
rtl/ce_pkg.sv
rtl/ce_gen.sv
rtl/download_router.sv
rtl/cheat_assembler.sv
rtl/cart_geometry.sv
rtl/rom_write_port.sv
rtl/sms_loader_top.sv
test/tb_clock.sv
test/tb_top.sv

// ==== rtl/cart_geometry.sv ====
// ====================================================================
// Cartridge geometry tracker
// Address masks learned from the download, header detection,
// registered mapping of console ROM reads into the image
// ====================================================================
`timescale 1ns/10ps

module cart_geometry #(
	parameter int ADDR_W = 22
) (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              cart_byte,
	input  logic              cart_end,
	input  logic [ADDR_W-1:0] byte_addr,
	input  logic [ADDR_W-1:0] cpu_rom_addr,
	output logic [ADDR_W-1:0] mem_rd_addr
);

	localparam logic [ADDR_W-1:0] HDR_OFS = ADDR_W'(cart_pkg::HEADER_BYTES);
	localparam int HDR_BIT = $clog2(cart_pkg::HEADER_BYTES); // Bit 9 for 512

	logic [ADDR_W-1:0] mask;
	logic [ADDR_W-1:0] mask512;    // Mask for images behind a header
	logic [ADDR_W-1:0] last_p1;    // Last address + 1, the image size
	logic              has_hdr;

	// ================================================================
	// Learn geometry while bytes stream in
	// ================================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			mask    <= '0;
			mask512 <= '0;
			last_p1 <= '0;
			has_hdr <= 1'b0;
		end else begin
			if (cart_byte) begin
				mask    <= (byte_addr == '0) ? '0 : (mask | byte_addr);
				mask512 <= (byte_addr == HDR_OFS) ? '0 : (mask512 | (byte_addr - HDR_OFS));
				last_p1 <= byte_addr + 1'b1;
			end
			if (cart_end)
				has_hdr <= last_p1[HDR_BIT]; // Odd 512-byte size means a header
		end
	end

	// ================================================================
	// ROM read mapping
	// ================================================================
	always_ff @(posedge clk_sys) begin
		if (has_hdr)
			mem_rd_addr <= (cpu_rom_addr + HDR_OFS) & mask512;
		else
			mem_rd_addr <= cpu_rom_addr & mask;
	end

endmodule

// ==== rtl/cart_pkg.sv ====
// ====================================================================
// Cartridge download constants
// Cheat record layout as a packed union of fields and byte lanes
// ====================================================================

package cart_pkg;

	// ================================================================
	// Download classification
	// ================================================================
	localparam logic [7:0] CHEAT_INDEX = 8'hff; // Cheat file slot
	localparam logic [4:0] GG_INDEX    = 5'd2;  // Handheld cart slot

	localparam int HEADER_BYTES = 512; // Optional copier header
	localparam int CHEAT_BYTES  = 16;

	// ================================================================
	// Cheat record
	// ================================================================
	// Fields from the top of the 128-bit word down
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Same word seen as 16 byte lanes, lane 15 on top
	typedef union packed {
		cheat_fields_t          f;
		logic [15:0][7:0]       lane;
	} cheat_code_t;

endpackage

// ==== rtl/ce_gen.sv ====
// ====================================================================
// Divide-by-30 clock-enable generator
// CPU, VDP, pixel and sprite enables from one phase counter
// ====================================================================
`timescale 1ns/10ps

module ce_gen (
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);

	logic [ce_pkg::CE_CNT_W-1:0] phase;

	// Phase counter, wraps after CE_DIV states
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (phase == ce_pkg::CE_CNT_W'(ce_pkg::CE_DIV - 1)) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// Enables land one edge after their phase
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			ce_cpu <= ce_pkg::CPU_PHASES[phase];
			ce_vdp <= ce_pkg::VDP_PHASES[phase];
			ce_pix <= ce_pkg::PIX_PHASES[phase];
			ce_sp  <= phase[0]; // Even length keeps this toggling every cycle
		end
	end

endmodule

// ==== rtl/ce_pkg.sv ====
// ====================================================================
// Clock-enable divider length and firing phases
// ====================================================================

package ce_pkg;

	localparam int CE_DIV   = 30;
	localparam int CE_CNT_W = $clog2(CE_DIV);

	// One bit per counter phase, set where the enable fires
	localparam logic [CE_DIV-1:0] VDP_PHASES = (30'd1 << 4) | (30'd1 << 9) | (30'd1 << 14)
		| (30'd1 << 19) | (30'd1 << 24) | (30'd1 << 29);
	localparam logic [CE_DIV-1:0] PIX_PHASES = (30'd1 << 9) | (30'd1 << 19) | (30'd1 << 29);
	localparam logic [CE_DIV-1:0] CPU_PHASES = (30'd1 << 9) | (30'd1 << 24);

endpackage

// ==== rtl/cheat_assembler.sv ====
// ====================================================================
// Cheat record assembler
// Packs 16 downloaded bytes into one flags/address/compare/replace word
// ====================================================================
`timescale 1ns/10ps

module cheat_assembler (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     cheat_byte,
	input  logic [3:0]               byte_addr,
	input  logic [7:0]               byte_data,
	output logic                     cheat_valid,
	output cart_pkg::cheat_code_t    cheat_code
);

	logic [3:0] lane_sel;
	logic       last_byte;

	// Offset groups 0..3 map to fields top down, each field LSB first.
	// Group g lands in lanes (3-g)*4 .. (3-g)*4+3
	assign lane_sel  = {~byte_addr[3:2], byte_addr[1:0]};
	assign last_byte = (byte_addr == 4'(cart_pkg::CHEAT_BYTES - 1));

	// Record storage, written one lane per byte
	always_ff @(posedge clk_sys) begin
		if (cheat_byte)
			cheat_code.lane[lane_sel] <= byte_data;
	end

	// Strobe once the final lane has been stored
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= cheat_byte & last_byte;
		end
	end

endmodule

// ==== rtl/download_router.sv ====
// ====================================================================
// Host download router
// Separates cartridge and cheat bytes, flags download start and end
// ====================================================================
`timescale 1ns/10ps

module download_router #(
	parameter int ADDR_W = 22
) (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              ioctl_download,
	input  logic [7:0]        ioctl_index,
	input  logic              ioctl_wr,
	input  logic [ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]        ioctl_dout,
	output logic              cart_start,
	output logic              cart_end,
	output logic              cart_byte,
	output logic              cheat_byte,
	output logic [ADDR_W-1:0] byte_addr,
	output logic [7:0]        byte_data,
	output logic              is_gg
);

	logic is_cheat;
	logic cart_dl;
	logic cart_dl_q;

	assign is_cheat = (ioctl_index == cart_pkg::CHEAT_INDEX);
	assign cart_dl  = ioctl_download & ~is_cheat;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cart_dl_q  <= 1'b0;
			cart_start <= 1'b0;
			cart_end   <= 1'b0;
			cart_byte  <= 1'b0;
			cheat_byte <= 1'b0;
			is_gg      <= 1'b0;
		end else begin
			cart_dl_q  <= cart_dl;
			cart_start <= cart_dl & ~cart_dl_q; // Rising edge of cart download
			cart_end   <= ~cart_dl & cart_dl_q;
			cart_byte  <= ioctl_wr & cart_dl;
			cheat_byte <= ioctl_wr & ioctl_download & is_cheat;
			if (ioctl_wr && cart_dl)
				is_gg <= (ioctl_index[4:0] == cart_pkg::GG_INDEX);
		end
	end

	// Byte payload shared by both streams
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr) begin
			byte_addr <= ioctl_addr;
			byte_data <= ioctl_dout;
		end
	end

endmodule

// ==== rtl/rom_write_port.sv ====
// ====================================================================
// ROM write port
// Toggle request/acknowledge writer with host back-pressure
// ====================================================================
`timescale 1ns/10ps

module rom_write_port #(
	parameter int WADDR_W = 24
) (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               cart_start,
	input  logic               cart_byte,
	input  logic [7:0]         byte_data,
	input  logic               rom_wr_ack,
	output logic               rom_wr_req,
	output logic [WADDR_W-1:0] rom_wr_addr,
	output logic [7:0]         rom_wr_data,
	output logic               ioctl_wait
);

	logic pending;
	logic done;

	assign done = pending & (rom_wr_ack == rom_wr_req);

	// Also high in the cycle before the request toggles
	assign ioctl_wait = pending | cart_byte;

	// Handshake state
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rom_wr_req <= 1'b0;
			pending    <= 1'b0;
		end else if (cart_byte) begin
			rom_wr_req <= ~rom_wr_req; // New request when req != ack
			pending    <= 1'b1;
		end else if (done) begin
			pending    <= 1'b0;
		end
	end

	// Write address, restarts at each download
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rom_wr_addr <= '0;
		end else if (cart_start) begin
			rom_wr_addr <= '0;
		end else if (done) begin
			rom_wr_addr <= rom_wr_addr + 1'b1;
		end
	end

	// Data held stable while the request is open
	always_ff @(posedge clk_sys) begin
		if (cart_byte)
			rom_wr_data <= byte_data;
	end

endmodule

// ==== rtl/sms_loader_top.sv ====
// ====================================================================
// Loader front end top level
// Download routing, ROM writer, geometry, cheats and clock enables
// ====================================================================
`timescale 1ns/10ps

module sms_loader_top #(
	parameter int ADDR_W  = 22,
	parameter int WADDR_W = 24
) (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	// Host download stream
	input  logic                  ioctl_download,
	input  logic [7:0]            ioctl_index,
	input  logic                  ioctl_wr,
	input  logic [ADDR_W-1:0]     ioctl_addr,
	input  logic [7:0]            ioctl_dout,
	output logic                  ioctl_wait,
	// ROM write port
	output logic                  rom_wr_req,
	output logic [WADDR_W-1:0]    rom_wr_addr,
	output logic [7:0]            rom_wr_data,
	input  logic                  rom_wr_ack,
	// ROM read mapping
	input  logic [ADDR_W-1:0]     cpu_rom_addr,
	output logic [ADDR_W-1:0]     mem_rd_addr,
	// Cheats and console controls
	output logic                  cheat_valid,
	output cart_pkg::cheat_code_t cheat_code,
	output logic                  is_gg,
	output logic                  ce_cpu,
	output logic                  ce_vdp,
	output logic                  ce_pix,
	output logic                  ce_sp
);

	logic              cart_start;
	logic              cart_end;
	logic              cart_byte;
	logic              cheat_byte;
	logic [ADDR_W-1:0] byte_addr;
	logic [7:0]        byte_data;

	// ================================================================
	// Input side
	// ================================================================
	download_router #(.ADDR_W(ADDR_W)) u_router (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.ioctl_download(ioctl_download),
		.ioctl_index   (ioctl_index),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.cart_start    (cart_start),
		.cart_end      (cart_end),
		.cart_byte     (cart_byte),
		.cheat_byte    (cheat_byte),
		.byte_addr     (byte_addr),
		.byte_data     (byte_data),
		.is_gg         (is_gg)
	);

	// ================================================================
	// Processing
	// ================================================================
	cart_geometry #(.ADDR_W(ADDR_W)) u_geometry (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.cart_byte   (cart_byte),
		.cart_end    (cart_end),
		.byte_addr   (byte_addr),
		.cpu_rom_addr(cpu_rom_addr),
		.mem_rd_addr (mem_rd_addr)
	);

	cheat_assembler u_cheat (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.cheat_byte (cheat_byte),
		.byte_addr  (byte_addr[3:0]), // Offset within the record
		.byte_data  (byte_data),
		.cheat_valid(cheat_valid),
		.cheat_code (cheat_code)
	);

	ce_gen u_ce_gen (
		.clk_sys(clk_sys),
		.rst_n  (rst_n),
		.ce_cpu (ce_cpu),
		.ce_vdp (ce_vdp),
		.ce_pix (ce_pix),
		.ce_sp  (ce_sp)
	);

	// ================================================================
	// Output side
	// ================================================================
	rom_write_port #(.WADDR_W(WADDR_W)) u_rom_wr (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.cart_start (cart_start),
		.cart_byte  (cart_byte),
		.byte_data  (byte_data),
		.rom_wr_ack (rom_wr_ack),
		.rom_wr_req (rom_wr_req),
		.rom_wr_addr(rom_wr_addr),
		.rom_wr_data(rom_wr_data),
		.ioctl_wait (ioctl_wait)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the loader testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps --top-module tb_top -f flist.f -o tb_sim

out=$(./obj_dir/tb_sim 2>&1) || true
echo "$out"

# Exit status follows the search for the pass line
echo "$out" | grep -q "ALL TESTS PASSED"

// ==== test/tb_clock.sv ====
// ====================================================================
// Testbench clock and power-on reset
// ====================================================================
`timescale 1ns/10ps

module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 5
) (
	output logic clk_sys,
	output logic rst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// Release on a rising edge, after the reset window
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		rst_n <= 1'b1;
	end

endmodule

// ==== test/tb_top.sv ====
// ====================================================================
// Testbench for the loader front end
// LFSR stimulus, ROM memory model, reference checks and watchdog
// ====================================================================
`timescale 1ns/10ps

module tb_top;

	localparam int ADDR_W  = 22;
	localparam int WADDR_W = 24;
	localparam int N_CARTS = 4;
	localparam int N_READS = 24;
	localparam int MAX_CYC = 16; // Worst host byte round trip is about 12
	localparam logic [ADDR_W-1:0] HDR = ADDR_W'(cart_pkg::HEADER_BYTES);

	logic                  clk_sys;
	logic                  rst_n;
	logic                  ioctl_download;
	logic [7:0]            ioctl_index;
	logic                  ioctl_wr;
	logic [ADDR_W-1:0]     ioctl_addr;
	logic [7:0]            ioctl_dout;
	logic                  ioctl_wait;
	logic                  rom_wr_req;
	logic [WADDR_W-1:0]    rom_wr_addr;
	logic [7:0]            rom_wr_data;
	logic                  rom_wr_ack;
	logic [ADDR_W-1:0]     cpu_rom_addr;
	logic [ADDR_W-1:0]     mem_rd_addr;
	logic                  cheat_valid;
	cart_pkg::cheat_code_t cheat_code;
	logic                  is_gg;
	logic                  ce_cpu;
	logic                  ce_vdp;
	logic                  ce_pix;
	logic                  ce_sp;

	logic [31:0]       stim_lfsr = 32'hf50b;
	logic [31:0]       mem_lfsr  = 32'hf50b;
	logic [7:0]        exp_rom[$];      // Bytes of the current cartridge
	int                wr_total = 0;    // Writes acknowledged so far
	int                dl_base = 0;     // wr_total at download start
	int                limit_cycles = 0;
	bit                in_cheat = 1'b0;
	logic [ADDR_W-1:0] m_mask = '0;     // Geometry model state
	logic [ADDR_W-1:0] m_mask512 = '0;
	logic [ADDR_W-1:0] m_last_p1 = '0;
	logic              m_hdr = 1'b0;

	tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(5)) clock0 (
		.clk_sys(clk_sys),
		.rst_n  (rst_n)
	);

	sms_loader_top #(.ADDR_W(ADDR_W), .WADDR_W(WADDR_W)) dut0 (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .ioctl_wait(ioctl_wait),
		.rom_wr_req(rom_wr_req), .rom_wr_addr(rom_wr_addr),
		.rom_wr_data(rom_wr_data), .rom_wr_ack(rom_wr_ack),
		.cpu_rom_addr(cpu_rom_addr), .mem_rd_addr(mem_rd_addr),
		.cheat_valid(cheat_valid), .cheat_code(cheat_code), .is_gg(is_gg),
		.ce_cpu(ce_cpu), .ce_vdp(ce_vdp), .ce_pix(ce_pix), .ce_sp(ce_sp)
	);

	// ================================================================
	// Helpers
	// ================================================================
	// Taps 32, 22, 2, 1; one step per bit taken
	function automatic logic [31:0] rand_bits(inout logic [31:0] st, input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			st = {st[30:0], st[31] ^ st[21] ^ st[1] ^ st[0]};
			r  = {r[30:0], st[0]};
		end
		return r;
	endfunction

	task automatic stop_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAIL %0t %s expected %0h actual %0h", $time, name, exp, act);
			stop_run();
		end
	endtask

	// Host byte write that waits for ioctl_wait low
	task automatic send_byte(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
		@(negedge clk_sys);
		while (ioctl_wait)
			@(negedge clk_sys);
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= addr;
		ioctl_dout <= data;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
	endtask

	// ================================================================
	// Test phases
	// ================================================================
	task automatic test_enables();
		int   n_cpu;
		int   n_vdp;
		int   n_pix;
		int   last_cpu;
		int   t;
		logic sp_prev;
		n_cpu = 0;
		n_vdp = 0;
		n_pix = 0;
		t     = 0;
		while (!ce_cpu && t < 60) begin
			@(negedge clk_sys);
			t++;
		end
		if (!ce_cpu) begin
			$display("ce_cpu never pulsed after reset");
			stop_run();
		end
		sp_prev  = ce_sp;
		last_cpu = 0;
		for (t = 0; t < 4 * 30; t++) begin // Windows start on a ce_cpu cycle
			if (t > 0) begin
				@(negedge clk_sys);
				check("ce_sp", 32'(!sp_prev), 32'(ce_sp));
				sp_prev = ce_sp;
			end
			if (ce_cpu) begin
				if (t > 0)
					check("ce_cpu gap", 32'd15, 32'(t - last_cpu));
				last_cpu = t;
				n_cpu++;
			end
			if (ce_vdp)
				n_vdp++;
			if (ce_pix)
				n_pix++;
			if (t % 30 == 29) begin
				check("ce_cpu count", 32'd2, 32'(n_cpu));
				check("ce_pix count", 32'd3, 32'(n_pix));
				check("ce_vdp count", 32'd6, 32'(n_vdp));
				n_cpu = 0;
				n_vdp = 0;
				n_pix = 0;
			end
		end
	endtask

	task automatic run_cart(input int len, input logic [7:0] idx);
		logic [7:0]        d;
		logic [ADDR_W-1:0] a;
		@(posedge clk_sys);
		exp_rom.delete();
		dl_base = wr_total;
		ioctl_index    <= idx;
		ioctl_download <= 1'b1;
		for (int i = 0; i < len; i++) begin
			d = 8'(rand_bits(stim_lfsr, 8));
			a = ADDR_W'(i);
			exp_rom.push_back(d);
			m_mask    = (a == '0) ? '0 : (m_mask | a);
			m_mask512 = (a == HDR) ? '0 : (m_mask512 | (a - HDR));
			m_last_p1 = a + 1'b1;
			send_byte(a, d);
		end
		@(negedge clk_sys);
		while (ioctl_wait) // Last write still open
			@(negedge clk_sys);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		m_hdr = m_last_p1[9]; // Size an odd multiple of 512
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check("rom write count", 32'(len), 32'(wr_total - dl_base));
		check("is_gg", 32'(idx[4:0] == cart_pkg::GG_INDEX), 32'(is_gg));
	endtask

	task automatic check_reads(input int n);
		logic [ADDR_W-1:0] a;
		logic [ADDR_W-1:0] exp;
		for (int i = 0; i < n; i++) begin
			a   = ADDR_W'(rand_bits(stim_lfsr, ADDR_W));
			exp = m_hdr ? ((a + HDR) & m_mask512) : (a & m_mask);
			@(posedge clk_sys);
			cpu_rom_addr <= a;
			@(posedge clk_sys);
			@(negedge clk_sys);
			check("mem_rd_addr", 32'(exp), 32'(mem_rd_addr));
		end
	endtask

	task automatic run_cheat();
		logic [7:0] b [16];
		int         n;
		@(posedge clk_sys);
		in_cheat = 1'b1;
		ioctl_index    <= cart_pkg::CHEAT_INDEX;
		ioctl_download <= 1'b1;
		for (int i = 0; i < cart_pkg::CHEAT_BYTES; i++) begin
			b[i] = 8'(rand_bits(stim_lfsr, 8));
			send_byte(ADDR_W'(i), b[i]);
		end
		n = 0;
		@(negedge clk_sys);
		while (!cheat_valid && n < 4) begin
			@(negedge clk_sys);
			n++;
		end
		if (!cheat_valid) begin
			$display("cheat_valid did not pulse after a full cheat record");
			stop_run();
		end else begin
			// Each field least significant byte first
			check("cheat flags", {b[3], b[2], b[1], b[0]}, cheat_code.f.flags);
			check("cheat address", {b[7], b[6], b[5], b[4]}, cheat_code.f.address);
			check("cheat compare", {b[11], b[10], b[9], b[8]}, cheat_code.f.compare);
			check("cheat replace", {b[15], b[14], b[13], b[12]}, cheat_code.f.replace);
		end
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		in_cheat = 1'b0;
	endtask

	// ================================================================
	// Memory model, watchdog and main sequence
	// ================================================================
	initial begin
		int delay;
		int n;
		forever begin
			@(negedge clk_sys);
			if (rst_n && rom_wr_req != rom_wr_ack) begin
				n = wr_total - dl_base;
				if (n >= exp_rom.size()) begin
					$display("ROM write request with no cartridge byte outstanding");
					stop_run();
				end else begin
					delay = int'(rand_bits(mem_lfsr, 3)); // 0 to 7 cycles
					for (int k = 0; k <= delay; k++) begin
						if (k > 0)
							@(negedge clk_sys);
						check("ioctl_wait", 32'd1, 32'(ioctl_wait));
						check("rom_wr_addr", 32'(n), 32'(rom_wr_addr));
						check("rom_wr_data", 32'(exp_rom[n]), 32'(rom_wr_data));
					end
					@(posedge clk_sys);
					rom_wr_ack <= rom_wr_req;
					wr_total++;
				end
			end
		end
	end

	always @(negedge clk_sys) begin
		if (in_cheat)
			check("ioctl_wait", 32'd0, 32'(ioctl_wait));
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles without finishing", limit_cycles);
		stop_run();
	end

	initial begin
		int         lens [N_CARTS];
		int         total;
		logic [7:0] idx;
		ioctl_download <= 1'b0;
		ioctl_index    <= '0;
		ioctl_wr       <= 1'b0;
		ioctl_addr     <= '0;
		ioctl_dout     <= '0;
		rom_wr_ack     <= 1'b0;
		cpu_rom_addr   <= '0;
		total = 0;
		for (int d = 0; d < N_CARTS; d++) begin
			if (d == 1)
				lens[d] = 16384 + cart_pkg::HEADER_BYTES; // Headered 16 KiB image
			else
				lens[d] = 513 + int'(rand_bits(stim_lfsr, 11));
			total += lens[d] + cart_pkg::CHEAT_BYTES;
		end
		limit_cycles = total * MAX_CYC + 4000;
		wait (rst_n);
		@(negedge clk_sys);
		check("ioctl_wait", 32'd0, 32'(ioctl_wait));
		check("cheat_valid", 32'd0, 32'(cheat_valid));
		check("is_gg", 32'd0, 32'(is_gg));
		check("rom_wr_req", 32'd0, 32'(rom_wr_req));
		check("ce_cpu", 32'd0, 32'(ce_cpu));
		check("ce_vdp", 32'd0, 32'(ce_vdp));
		check("ce_pix", 32'd0, 32'(ce_pix));
		check("ce_sp", 32'd0, 32'(ce_sp));
		test_enables();
		for (int d = 0; d < N_CARTS; d++) begin
			idx = 8'(rand_bits(stim_lfsr, 8));
			if (d % 2 == 1)
				idx[4:0] = cart_pkg::GG_INDEX; // Handheld slot on odd downloads
			else if (idx[4:0] == cart_pkg::GG_INDEX)
				idx[4:0] = 5'd3;
			if (idx == cart_pkg::CHEAT_INDEX)
				idx = 8'hfe;
			run_cart(lens[d], idx);
			check_reads(N_READS);
			run_cheat();
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule
